// File: Bender.yml
package:
  name: tio_hsk

sources:
  - verilog/hsk_pkg.sv
  - verilog/hsk_wb_decode.sv
  - verilog/hsk_ctrl_regs.sv
  - verilog/clk_mon_gate.sv
  - verilog/clk_mon_channel.sv
  - verilog/clk_mon_readout.sv
  - verilog/tio_hsk_top.sv
  - target: test
    files:
      - bench/tb_tio_hsk.sv

// File: bench/tb_tio_hsk.sv
`timescale 1ns/1ps
`default_nettype none
module tb_tio_hsk import hsk_pkg::*; ();

    localparam int NCLK = 5;
    localparam int GATE = 64;
    localparam logic [31:0] TB_ID = "TFIO";
    localparam logic [31:0] TB_VER = 32'h0002_0105;

    logic wb_clk_i = 1'b0;
    logic wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [11:0] wb_adr_i;
    logic [31:0] wb_dat_i, wb_dat_o;
    logic [3:0] wb_sel_i;
    logic hsk_en_valid_i, hsk_en_val_i, hsk_local_i, hskbus_crate_i, i2c_rdy_i;
    logic [7:0] hskbus_rx_bytes_i;
    logic [1:0] crate_conf_i;
    logic [NCLK-1:0] mon_clk_i = '0;
    logic [NCLK-1:0] run_clk = '1;
    logic [NCLK-1:0] clk_running_o;
    hsk_ctrl_t ctrl_o;
    // Reference model of the control fields and the clock ok bits
    hsk_ctrl_t exp_ctrl;
    logic [1:0] exp_ok = 2'b00;
    integer seed = 32'h8e76_750e;
    int errors = 0;
    int checks = 0;

    tio_hsk_top #(.NUM_CLOCKS(NCLK), .GATE_CYCLES(GATE), .DEVICE_ID(TB_ID),
                  .VERSION(TB_VER)) dut0 (.*);

    always #20 wb_clk_i = ~wb_clk_i;

    // Periods 40, 32, 40, 20 and 25 ns
    function automatic real half_period(input int i);
        case (i)
            1: return 16.0;
            3: return 10.0;
            4: return 12.5;
            default: return 20.0;
        endcase
    endfunction

    // Edges per window against the 40 ns bus clock
    function automatic int expected_count(input int i);
        return int'(GATE * 40.0 / (2.0 * half_period(i)));
    endfunction

    // Small offsets keep monitored edges off the bus clock edges
    for (genvar i = 0; i < NCLK; i++) begin : g_mon_clk
        initial begin
            #(i + 1);
            forever begin
                #(half_period(i));
                // Cleared run bit freezes the clock
                if (run_clk[i]) mon_clk_i[i] = ~mon_clk_i[i];
            end
        end
    end

    // Read value expected from the register layout
    function automatic logic [31:0] expect_word(input logic [11:0] adr);
        case (adr)
            REG_DEVICE:   return TB_ID;
            REG_VERSION:  return TB_VER;
            REG_CTRLSTAT: return {8'h0, hskbus_rx_bytes_i, 4'h0, exp_ctrl.calpwdn,
                                  exp_ctrl.calsel, crate_conf_i, exp_ctrl.sysclk_rst,
                                  hskbus_crate_i, hsk_local_i, i2c_rdy_i,
                                  exp_ctrl.enable_3v3, exp_ctrl.enable_crate, exp_ok};
            REG_SYNC:     return {23'h0, exp_ctrl.en_ext_sync, exp_ctrl.sync_offset};
            REG_CLKOFS:   return {24'h0, exp_ctrl.clk_offset};
            REG_BOARDMAN: return {exp_ctrl.burst_size, 5'h0, exp_ctrl.upper_addr, 21'h0};
            default:      return 32'h0;
        endcase
    endfunction

    // Model update for a write with byte lanes per field
    task automatic model_write(input logic [11:0] adr, input logic [31:0] d,
                               input logic [3:0] sel);
        if (adr == REG_CTRLSTAT && sel[0]) begin
            exp_ctrl.enable_crate = d[2];
            exp_ctrl.enable_3v3 = d[3];
            exp_ctrl.sysclk_rst = d[7];
        end
        if (adr == REG_CTRLSTAT && sel[1]) begin
            exp_ctrl.calsel = d[10];
            exp_ctrl.calpwdn = d[11];
        end
        if (adr == REG_SYNC && sel[0]) exp_ctrl.sync_offset = d[7:0];
        if (adr == REG_SYNC && sel[1]) exp_ctrl.en_ext_sync = d[8];
        if (adr == REG_CLKOFS && sel[0]) exp_ctrl.clk_offset = d[7:0];
        if (adr == REG_BOARDMAN && sel[0]) exp_ctrl.burst_size = d[1:0];
        if (adr == REG_BOARDMAN && sel[2]) exp_ctrl.upper_addr[2:0] = d[23:21];
        if (adr == REG_BOARDMAN && sel[3]) exp_ctrl.upper_addr[3] = d[24];
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input logic [31:0] got, input int exp);
        checks++;
        assert (got <= 32'(exp + 2) && int'(got) >= exp - 2) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d +-2", $time, name, got, exp);
        end
    endtask

    task automatic verify_ctrl();
        compare_word("ctrl_o", {4'h0, ctrl_o}, {4'h0, exp_ctrl});
    endtask

    // Ack comes after one registered wait state
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge wb_clk_i);
            n++;
        end while (!wb_ack_o && n < 16);
        if (!wb_ack_o) begin
            errors++;
            $display("Timeout: no bus acknowledge for address %h", wb_adr_i);
        end
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] d);
        wb_adr_i = adr;
        wb_we_i = 1'b0;
        wb_sel_i = 4'hF;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wait_ack();
        d = wb_dat_o;
        // Ack lasts one cycle even with the strobe still held
        @(negedge wb_clk_i);
        checks++;
        assert (wb_ack_o === 1'b0) else begin
            errors++;
            $display("Bus acknowledge for address %h lasted more than one cycle", wb_adr_i);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] d,
                            input logic [3:0] sel);
        wb_adr_i = adr;
        wb_dat_i = d;
        wb_sel_i = sel;
        wb_we_i = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        model_write(adr, d, sel);
        wait_ack();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        // Write lands on the edge that closes the ack
        @(negedge wb_clk_i);
        wb_we_i = 1'b0;
    endtask

    task automatic verify_reg(input logic [11:0] adr, input string name);
        logic [31:0] d;
        wb_read(adr, d);
        compare_word(name, d, expect_word(adr));
    endtask

    task automatic wait_running(input int ch, input logic val);
        int n;
        n = 0;
        while (clk_running_o[ch] !== val && n < 4 * GATE) begin
            @(negedge wb_clk_i);
            n++;
        end
        if (clk_running_o[ch] !== val) begin
            errors++;
            $display("Timeout: running flag %0d never became %0b", ch, val);
        end
    endtask

    // Runs before the first gate while the ok bits are still low
    task automatic reset_values();
        verify_ctrl();
        verify_reg(REG_DEVICE, "device id");
        verify_reg(REG_VERSION, "version");
        verify_reg(REG_CTRLSTAT, "ctrl/status");
        // DNA slot and unmapped space read zero
        verify_reg(12'h008, "dna slot");
        verify_reg(12'h100, "unmapped word");
    endtask

    task automatic monitor_counts();
        logic [31:0] d;
        for (int i = 0; i < NCLK; i++) wait_running(i, 1'b1);
        // One more full window so every count is complete
        repeat (GATE) @(negedge wb_clk_i);
        for (int i = 0; i < NCLK; i++) begin
            wb_read(CLKMON_BASE + 12'(4 * i), d);
            compare_count($sformatf("count %0d", i), d, expected_count(i));
        end
        wb_read(CLKMON_BASE + 12'(4 * NCLK), d);
        compare_word("count past last channel", d, 32'h0);
        compare_word("clk_running_o", 32'(clk_running_o), 32'h1F);
        // Sys and rx clocks now reported ok
        exp_ok = 2'b11;
        verify_reg(REG_CTRLSTAT, "ctrl/status ok bits");
    endtask

    task automatic reg_readback();
        logic [31:0] d;
        d = $random(seed);
        wb_write(REG_SYNC, d, 4'hF);
        verify_reg(REG_SYNC, "sync");
        d = $random(seed);
        wb_write(REG_CLKOFS, d, 4'hF);
        verify_reg(REG_CLKOFS, "clock offset");
        d = $random(seed);
        wb_write(REG_BOARDMAN, d, 4'hF);
        verify_reg(REG_BOARDMAN, "board manager");
        verify_ctrl();
        // Partial lanes leave the others alone
        d = $random(seed);
        wb_write(REG_SYNC, d, 4'b0010);
        verify_reg(REG_SYNC, "sync lane 1");
        d = $random(seed);
        wb_write(REG_BOARDMAN, d, 4'b0100);
        verify_reg(REG_BOARDMAN, "board manager lane 2");
        d = $random(seed);
        wb_write(REG_BOARDMAN, d, 4'b1001);
        verify_reg(REG_BOARDMAN, "board manager lanes 0 3");
        verify_ctrl();
    endtask

    task automatic ctrlstat_access();
        logic [31:0] d;
        wb_write(REG_CTRLSTAT, 32'hFFFF_FFFF, 4'hF);
        verify_ctrl();
        verify_reg(REG_CTRLSTAT, "ctrl/status all set");
        wb_write(REG_CTRLSTAT, 32'h0, 4'b0001);
        verify_ctrl();
        verify_reg(REG_CTRLSTAT, "ctrl/status lane 0 clear");
        wb_write(REG_CTRLSTAT, 32'h0, 4'b0010);
        verify_ctrl();
        verify_reg(REG_CTRLSTAT, "ctrl/status lane 1 clear");
        // Status side follows the pins
        crate_conf_i = 2'b10;
        i2c_rdy_i = 1'b0;
        hsk_local_i = 1'b0;
        hskbus_crate_i = 1'b0;
        d = $random(seed);
        hskbus_rx_bytes_i = d[7:0];
        verify_reg(REG_CTRLSTAT, "ctrl/status pins");
    endtask

    task automatic hsk_override();
        hsk_en_valid_i = 1'b1;
        hsk_en_val_i = 1'b0;
        @(negedge wb_clk_i);
        exp_ctrl.enable_crate = 1'b0;
        verify_ctrl();
        hsk_en_val_i = 1'b1;
        @(negedge wb_clk_i);
        exp_ctrl.enable_crate = 1'b1;
        verify_ctrl();
        hsk_en_val_i = 1'b0;
        @(negedge wb_clk_i);
        exp_ctrl.enable_crate = 1'b0;
        verify_ctrl();
        // Bus sets the crate enable while the controller drives zero
        wb_write(REG_CTRLSTAT, expect_word(REG_CTRLSTAT) | 32'h4, 4'b0001);
        verify_ctrl();
        hsk_en_valid_i = 1'b0;
        repeat (3) @(negedge wb_clk_i);
        verify_ctrl();
    endtask

    task automatic clock_stop();
        logic [31:0] d;
        run_clk[4] = 1'b0;
        wait_running(4, 1'b0);
        wb_read(CLKMON_BASE + 12'h010, d);
        compare_word("count 4 stopped", d, 32'h0);
        run_clk[4] = 1'b1;
        wait_running(4, 1'b1);
        repeat (GATE) @(negedge wb_clk_i);
        wb_read(CLKMON_BASE + 12'h010, d);
        compare_count("count 4 restarted", d, expected_count(4));
        compare_word("clk_running_o", 32'(clk_running_o), 32'h1F);
    endtask

    // Watchdog
    initial begin
        #(1_000_000);
        $display("Timeout: simulation did not finish in time");
        $display("Test failures found");
        $finish;
    end

    initial begin
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        hsk_en_valid_i = 1'b0;
        hsk_en_val_i = 1'b0;
        hsk_local_i = 1'b1;
        hskbus_crate_i = 1'b1;
        hskbus_rx_bytes_i = 8'hA5;
        crate_conf_i = 2'b01;
        i2c_rdy_i = 1'b1;
        exp_ctrl = '{sync_offset: SYNC_OFFSET_DEFAULT, en_ext_sync: 1'b0, clk_offset: 8'h0,
                     burst_size: 2'h0, upper_addr: 4'h0, sysclk_rst: 1'b1,
                     enable_crate: 1'b1, enable_3v3: 1'b1, calsel: 1'b0, calpwdn: 1'b1};
        repeat (5) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;
        reset_values();
        monitor_counts();
        reg_readback();
        ctrlstat_access();
        hsk_override();
        clock_stop();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
`default_nettype wire

// File: compile.f
verilog/hsk_pkg.sv
verilog/hsk_wb_decode.sv
verilog/hsk_ctrl_regs.sv
verilog/clk_mon_gate.sv
verilog/clk_mon_channel.sv
verilog/clk_mon_readout.sv
verilog/tio_hsk_top.sv
bench/tb_tio_hsk.sv

// File: verilog/clk_mon_channel.sv
`timescale 1ns/1ps
`default_nettype none
module clk_mon_channel (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        mon_clk_i,
    input  logic        gate_i,
    output logic [15:0] count_o
);

    // Only steps between samples matter, so the start value is free
    logic [2:0]  mon_bin_q = '0;
    logic [2:0]  mon_gray_q = '0;
    logic [2:0]  gray_s1;
    logic [2:0]  gray_s2;
    logic [2:0]  bin_prev;
    logic [2:0]  bin_cur;
    logic [2:0]  step;
    logic [15:0] acc_q;

    function automatic logic [2:0] gray2bin(input logic [2:0] g);
        gray2bin = {g[2], g[2] ^ g[1], g[2] ^ g[1] ^ g[0]};
    endfunction

    // Monitored clock domain, one Gray step per edge
    always_ff @(posedge mon_clk_i) begin
        mon_bin_q  <= mon_bin_q + 3'd1;
        mon_gray_q <= (mon_bin_q + 3'd1) ^ ((mon_bin_q + 3'd1) >> 1);
    end

    // Two-flop synchronizer, Gray code keeps each sample coherent
    always_ff @(posedge wb_clk_i) begin
        gray_s1  <= mon_gray_q;
        gray_s2  <= gray_s1;
        bin_prev <= bin_cur;
    end

    assign bin_cur = gray2bin(gray_s2);
    // Modulo-8 difference since the previous sample
    assign step    = bin_cur - bin_prev;

    // Accumulate edges, dump and restart on the gate
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            acc_q   <= '0;
            count_o <= '0;
        end else if (gate_i) begin
            count_o <= acc_q + 16'(step);
            acc_q   <= '0;
        end else begin
            acc_q   <= acc_q + 16'(step);
        end
    end

endmodule
`default_nettype wire

// File: verilog/clk_mon_gate.sv
`timescale 1ns/1ps
`default_nettype none
module clk_mon_gate #(
    parameter int GATE_CYCLES = 1024
) (
    input  logic wb_clk_i,
    input  logic wb_rst_i,
    output logic gate_o
);

    localparam int CW = $clog2(GATE_CYCLES + 1);

    logic [CW-1:0] cnt_q;

    // Counts down from GATE_CYCLES-1, gate fires on the reload
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cnt_q  <= CW'(GATE_CYCLES - 1);
            gate_o <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= CW'(GATE_CYCLES - 1);
            gate_o <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            gate_o <= 1'b0;
        end
    end

endmodule
`default_nettype wire

// File: verilog/clk_mon_readout.sv
`timescale 1ns/1ps
`default_nettype none
module clk_mon_readout import hsk_pkg::*; #(
    parameter int NUM_CLOCKS = 5
) (
    input  logic                        wb_clk_i,
    input  logic                        wb_rst_i,
    input  wb_req_t                     req_i,
    input  logic [NUM_CLOCKS-1:0][15:0] counts_i,
    input  logic                        gate_i,
    output logic [31:0]                 dat_o,
    output logic [NUM_CLOCKS-1:0]       clk_running_o
);

    logic [3:0] idx;
    logic       gate_d;

    // Channel index from the word address
    assign idx = req_i.adr[5:2];

    // Missing channels read zero
    always_comb begin
        if (int'(idx) < NUM_CLOCKS) dat_o = {16'h0, counts_i[idx]};
        else dat_o = '0;
    end

    // Counts are fresh one cycle after the gate
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            gate_d        <= 1'b0;
            clk_running_o <= '0;
        end else begin
            gate_d <= gate_i;
            if (gate_d) begin
                for (int i = 0; i < NUM_CLOCKS; i++) clk_running_o[i] <= |counts_i[i];
            end
        end
    end

endmodule
`default_nettype wire

// File: verilog/hsk_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none
module hsk_ctrl_regs import hsk_pkg::*; #(
    parameter logic [31:0] DEVICE_ID = "TFIO",
    parameter logic [31:0] VERSION   = 32'h0
) (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  wb_req_t     req_i,
    input  logic        acc_i,
    output logic [31:0] dat_o,
    input  logic        hsk_en_valid_i,
    input  logic        hsk_en_val_i,
    input  logic        hsk_local_i,
    input  logic        hskbus_crate_i,
    input  logic [7:0]  hskbus_rx_bytes_i,
    input  logic [1:0]  crate_conf_i,
    input  logic        i2c_rdy_i,
    input  logic        sys_clk_ok_i,
    input  logic        rx_clk_ok_i,
    output hsk_ctrl_t   ctrl_o
);

    logic [11:0] word_adr;
    logic        wr_en;
    logic        wr_ctrlstat;
    logic        wr_sync;
    logic        wr_clkofs;
    logic        wr_boardman;
    hsk_ctrl_t   ctrl_q;
    logic [1:0]  crate_conf_q;
    logic        i2c_rdy_q;
    logic [31:0] ctrlstat;
    logic [31:0] boardman;

    // Byte lanes ignored for decode
    assign word_adr    = {req_i.adr[11:2], 2'b00};
    assign wr_en       = acc_i && req_i.we;
    assign wr_ctrlstat = wr_en && (word_adr == REG_CTRLSTAT);
    assign wr_sync     = wr_en && (word_adr == REG_SYNC);
    assign wr_clkofs   = wr_en && (word_adr == REG_CLKOFS);
    assign wr_boardman = wr_en && (word_adr == REG_BOARDMAN);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_q.sync_offset  <= SYNC_OFFSET_DEFAULT;
            ctrl_q.en_ext_sync  <= 1'b0;
            ctrl_q.clk_offset   <= '0;
            ctrl_q.burst_size   <= '0;
            ctrl_q.upper_addr   <= '0;
            // PLL held in reset until software releases it
            ctrl_q.sysclk_rst   <= 1'b1;
            ctrl_q.enable_crate <= 1'b1;
            ctrl_q.enable_3v3   <= 1'b1;
            ctrl_q.calsel       <= 1'b0;
            ctrl_q.calpwdn      <= 1'b1;
        end else begin
            // Bus write beats the housekeeping controller
            if (wr_ctrlstat && req_i.sel[0]) ctrl_q.enable_crate <= req_i.dat[2];
            else if (hsk_en_valid_i) ctrl_q.enable_crate <= hsk_en_val_i;
            if (wr_ctrlstat && req_i.sel[0]) begin
                ctrl_q.enable_3v3 <= req_i.dat[3];
                ctrl_q.sysclk_rst <= req_i.dat[7];
            end
            if (wr_ctrlstat && req_i.sel[1]) begin
                ctrl_q.calsel  <= req_i.dat[10];
                ctrl_q.calpwdn <= req_i.dat[11];
            end
            // Sync offset low byte, external sync enable bit 8
            if (wr_sync && req_i.sel[0]) ctrl_q.sync_offset <= req_i.dat[7:0];
            if (wr_sync && req_i.sel[1]) ctrl_q.en_ext_sync <= req_i.dat[8];
            if (wr_clkofs && req_i.sel[0]) ctrl_q.clk_offset <= req_i.dat[7:0];
            // Burst size comes from the low bits, reads back at the top
            if (wr_boardman && req_i.sel[0]) ctrl_q.burst_size <= req_i.dat[1:0];
            // Upper address straddles lanes 2 and 3
            if (wr_boardman && req_i.sel[2]) ctrl_q.upper_addr[2:0] <= req_i.dat[23:21];
            if (wr_boardman && req_i.sel[3]) ctrl_q.upper_addr[3] <= req_i.dat[24];
        end
    end

    // Pin inputs sampled once
    always_ff @(posedge wb_clk_i) begin
        crate_conf_q <= crate_conf_i;
        i2c_rdy_q    <= i2c_rdy_i;
    end

    assign ctrlstat = {8'h00, hskbus_rx_bytes_i, 4'h0,
                       ctrl_q.calpwdn, ctrl_q.calsel, crate_conf_q, ctrl_q.sysclk_rst,
                       hskbus_crate_i, hsk_local_i, i2c_rdy_q,
                       ctrl_q.enable_3v3, ctrl_q.enable_crate, rx_clk_ok_i, sys_clk_ok_i};
    assign boardman = {ctrl_q.burst_size, 5'b0, ctrl_q.upper_addr, 21'b0};

    // Unlisted words, DNA slot included, read zero
    always_comb begin
        case (word_adr)
            REG_DEVICE:   dat_o = DEVICE_ID;
            REG_VERSION:  dat_o = VERSION;
            REG_CTRLSTAT: dat_o = ctrlstat;
            REG_SYNC:     dat_o = {23'b0, ctrl_q.en_ext_sync, ctrl_q.sync_offset};
            REG_CLKOFS:   dat_o = {24'b0, ctrl_q.clk_offset};
            REG_BOARDMAN: dat_o = boardman;
            default:      dat_o = '0;
        endcase
    end

    assign ctrl_o = ctrl_q;

endmodule
`default_nettype wire

// File: verilog/hsk_pkg.sv
`default_nettype none
// Shared types and address map of the housekeeping register block
package hsk_pkg;

    // Wishbone request as seen by the targets
    typedef struct packed {
        logic [11:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
    } wb_req_t;

    // Which target an access goes to
    typedef enum logic [1:0] {
        TGT_REGS,
        TGT_CLKMON,
        TGT_NONE
    } hsk_target_e;

    // Control outputs toward the rest of the board
    typedef struct packed {
        logic [7:0] sync_offset;
        logic       en_ext_sync;
        logic [7:0] clk_offset;
        logic [1:0] burst_size;
        logic [3:0] upper_addr;
        logic       sysclk_rst;
        logic       enable_crate;
        logic       enable_3v3;
        logic       calsel;
        logic       calpwdn;
    } hsk_ctrl_t;

    // Byte addresses of the register words
    localparam logic [11:0] REG_DEVICE   = 12'h000;
    localparam logic [11:0] REG_VERSION  = 12'h004;
    localparam logic [11:0] REG_CTRLSTAT = 12'h00C;
    localparam logic [11:0] REG_SYNC     = 12'h010;
    localparam logic [11:0] REG_CLKOFS   = 12'h014;
    localparam logic [11:0] REG_BOARDMAN = 12'h018;
    // Clock monitor window, one word per channel
    localparam logic [11:0] CLKMON_BASE  = 12'h040;

    // Sysclks to wait after a sync sequence, out of reset
    localparam logic [7:0] SYNC_OFFSET_DEFAULT = 8'd8;

endpackage
`default_nettype wire

// File: verilog/hsk_wb_decode.sv
`timescale 1ns/1ps
`default_nettype none
module hsk_wb_decode import hsk_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [11:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output wb_req_t     req_o,
    output logic        regs_acc_o,
    output logic        mon_acc_o,
    input  logic [31:0] regs_dat_i,
    input  logic [31:0] mon_dat_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o
);

    hsk_target_e tgt;
    logic        ack_q;

    // Request fields pass straight to the targets
    assign req_o = '{adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i, we: wb_we_i};

    // 64-byte pages: page 0 registers, page 1 clock monitors
    always_comb begin
        if (wb_adr_i[11:6] == REG_DEVICE[11:6]) tgt = TGT_REGS;
        else if (wb_adr_i[11:6] == CLKMON_BASE[11:6]) tgt = TGT_CLKMON;
        else tgt = TGT_NONE;
    end

    // Single wait state; a held strobe gets an ack every other cycle
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) ack_q <= 1'b0;
        else ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
    end

    assign wb_ack_o   = ack_q;
    // Access pulse coincides with ack
    assign regs_acc_o = ack_q && (tgt == TGT_REGS);
    assign mon_acc_o  = ack_q && (tgt == TGT_CLKMON);

    // Read data by target, unmapped space is zero
    always_comb begin
        case (tgt)
            TGT_REGS:   wb_dat_o = regs_dat_i;
            TGT_CLKMON: wb_dat_o = mon_dat_i;
            default:    wb_dat_o = '0;
        endcase
    end

endmodule
`default_nettype wire

// File: verilog/tio_hsk_top.sv
`timescale 1ns/1ps
`default_nettype none
module tio_hsk_top import hsk_pkg::*; #(
    parameter int          NUM_CLOCKS  = 5,
    parameter int          GATE_CYCLES = 1024,
    parameter logic [31:0] DEVICE_ID   = "TFIO",
    parameter logic [31:0] VERSION     = 32'h0
) (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [11:0]           wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    output logic                  wb_ack_o,
    output logic [31:0]           wb_dat_o,
    input  logic                  hsk_en_valid_i,
    input  logic                  hsk_en_val_i,
    input  logic                  hsk_local_i,
    input  logic                  hskbus_crate_i,
    input  logic [7:0]            hskbus_rx_bytes_i,
    input  logic [1:0]            crate_conf_i,
    input  logic                  i2c_rdy_i,
    input  logic [NUM_CLOCKS-1:0] mon_clk_i,
    output hsk_ctrl_t             ctrl_o,
    output logic [NUM_CLOCKS-1:0] clk_running_o
);

    wb_req_t                     req;
    logic                        regs_acc;
    logic [31:0]                 regs_dat;
    logic [31:0]                 mon_dat;
    logic                        gate;
    logic [NUM_CLOCKS-1:0][15:0] counts;

    // Clock monitor has no writable state, its access pulse stays open
    hsk_wb_decode u_decode (
        .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
        .req_o(req), .regs_acc_o(regs_acc), .mon_acc_o(),
        .regs_dat_i(regs_dat), .mon_dat_i(mon_dat), .wb_ack_o, .wb_dat_o
    );

    // Clock 0 is the sys clock, clock 2 the rx clock
    hsk_ctrl_regs #(.DEVICE_ID(DEVICE_ID), .VERSION(VERSION)) u_regs (
        .wb_clk_i, .wb_rst_i, .req_i(req), .acc_i(regs_acc), .dat_o(regs_dat),
        .hsk_en_valid_i, .hsk_en_val_i, .hsk_local_i, .hskbus_crate_i, .hskbus_rx_bytes_i,
        .crate_conf_i, .i2c_rdy_i,
        .sys_clk_ok_i(clk_running_o[0]), .rx_clk_ok_i(clk_running_o[2]), .ctrl_o
    );

    clk_mon_gate #(.GATE_CYCLES(GATE_CYCLES)) u_gate (.wb_clk_i, .wb_rst_i, .gate_o(gate));

    // One monitor per incoming clock
    for (genvar g = 0; g < NUM_CLOCKS; g++) begin : g_mon
        clk_mon_channel u_chan (
            .wb_clk_i, .wb_rst_i, .mon_clk_i(mon_clk_i[g]), .gate_i(gate), .count_o(counts[g])
        );
    end

    clk_mon_readout #(.NUM_CLOCKS(NUM_CLOCKS)) u_readout (
        .wb_clk_i, .wb_rst_i, .req_i(req), .counts_i(counts), .gate_i(gate),
        .dat_o(mon_dat), .clk_running_o
    );

endmodule
`default_nettype wire
